// File: common/core_bus_pkg.sv
// ====================
// port payloads of the core; strobes are single cycle, no back-pressure
// ====================
`default_nettype none

package core_bus_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] inst;
    } fetch_rsp_t;

    // one per retired instruction
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            we;       // write intent, also set for rd == x0
        logic            illegal;
    } retire_t;

    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
    } wb_t;

endpackage

`default_nettype wire

// File: common/rv_isa_pkg.sv
// ====================
// RV32I integer subset only: no loads, stores or SYSTEM opcodes
// ====================
`default_nettype none

package rv_isa_pkg;

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_t;

    // selects immediate format and operand sources
    typedef enum logic [2:0] {
        CLASS_R,
        CLASS_I,
        CLASS_U,
        CLASS_B,
        CLASS_J,
        CLASS_NONE  // unrecognised opcode
    } inst_class_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // branch conditions in funct3
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    typedef struct packed {
        inst_class_t op_class;
        logic [6:0]  opcode;   // raw field, may hold an illegal value
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        illegal;
        logic [31:0] pc;
        logic [31:0] snpc;
    } decoded_t;

endpackage

`default_nettype wire

// File: decode/inst_decoder.sv
// ====================
// purely combinational; opcodes outside the kept subset flag illegal
// ====================
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic [core_bus_pkg::XLEN-1:0] inst,
    input  logic [core_bus_pkg::XLEN-1:0] pc,
    output rv_isa_pkg::decoded_t          decoded
);

    logic [6:0] funct7;

    assign funct7 = inst[31:25];

    always_comb begin
        decoded         = '0;
        decoded.opcode  = inst[6:0];
        decoded.funct3  = inst[14:12];
        decoded.rd      = inst[11:7];
        decoded.rs1     = inst[19:15];
        decoded.rs2     = inst[24:20];
        decoded.pc      = pc;
        decoded.snpc    = pc + 32'd4;

        case (inst[6:0])
            rv_isa_pkg::OPC_OP:
                decoded.op_class = rv_isa_pkg::CLASS_R;
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_JALR:
                decoded.op_class = rv_isa_pkg::CLASS_I;
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC:
                decoded.op_class = rv_isa_pkg::CLASS_U;
            rv_isa_pkg::OPC_BRANCH:
                decoded.op_class = rv_isa_pkg::CLASS_B;
            rv_isa_pkg::OPC_JAL:
                decoded.op_class = rv_isa_pkg::CLASS_J;
            default: begin
                decoded.op_class = rv_isa_pkg::CLASS_NONE;
                decoded.illegal  = 1'b1;
            end
        endcase

        case (decoded.op_class)
            rv_isa_pkg::CLASS_I: decoded.imm = {{20{inst[31]}}, inst[31:20]};
            rv_isa_pkg::CLASS_U: decoded.imm = {inst[31:12], 12'b0};
            rv_isa_pkg::CLASS_B:
                decoded.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_isa_pkg::CLASS_J:
                decoded.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
                               1'b0};
            default: decoded.imm = '0;  // R-type and illegal carry no immediate
        endcase

        // address adds for everything outside OP / OP-IMM
        decoded.alu_op = rv_isa_pkg::ALU_ADD;
        if (inst[6:0] == rv_isa_pkg::OPC_OP || inst[6:0] == rv_isa_pkg::OPC_OP_IMM) begin
            case (inst[14:12])
                3'b000: if (decoded.op_class == rv_isa_pkg::CLASS_R && funct7[5])
                    decoded.alu_op = rv_isa_pkg::ALU_SUB;  // ADDI has no SUB form
                3'b001: decoded.alu_op = rv_isa_pkg::ALU_SLL;
                3'b010: decoded.alu_op = rv_isa_pkg::ALU_SLT;
                3'b011: decoded.alu_op = rv_isa_pkg::ALU_SLTU;
                3'b100: decoded.alu_op = rv_isa_pkg::ALU_XOR;
                3'b101: decoded.alu_op = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
                3'b110: decoded.alu_op = rv_isa_pkg::ALU_OR;
                default: decoded.alu_op = rv_isa_pkg::ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dv/rv_core_tb.sv
// ====================
// instruction memory answers 1 to 4 cycles after each request
// the trace table must list rows in retirement order
// ====================
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        we;
        logic        illegal;
    } trace_row_t;

    logic                     clk;
    logic                     reset;
    core_bus_pkg::fetch_req_t fetch_req;
    core_bus_pkg::fetch_rsp_t fetch_rsp;
    core_bus_pkg::retire_t    retire;

    logic [31:0] imem [64];
    trace_row_t  trace [$];
    integer      seed = 62;
    logic        first_fetch = 1'b1;

    rv_core uut (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s within 50 cycles", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on timeout");
    endtask

    // places the word in memory and queues the expected retire
    task automatic add_row(input logic [7:0] offset, input logic [31:0] inst,
                           input logic [7:0] next_off, input logic [4:0] rd,
                           input logic [31:0] wdata, input logic we, input logic illegal);
        trace_row_t row;
        row.pc      = core_bus_pkg::RESET_PC + offset;
        row.next_pc = core_bus_pkg::RESET_PC + next_off;
        row.rd      = rd;
        row.wdata   = wdata;
        row.we      = we;
        row.illegal = illegal;
        imem[offset >> 2] = inst;
        trace.push_back(row);
    endtask

    task automatic build_program();
        logic [31:0] addr;
        for (int i = 0; i < 64; i++) begin
            addr    = core_bus_pkg::RESET_PC + 32'(i * 4);
            imem[i] = {addr[31:7] ^ {20'd0, addr[6:2]}, 7'h7f};  // illegal opcode everywhere
        end
        // offset, instruction, next offset, rd, wdata, we, illegal
        add_row(8'h00, enc_i(12'd5, 0, 3'b000, 1, 7'b0010011), 8'h04, 1, 32'd5, 1, 0);
        add_row(8'h04, enc_i(12'hffd, 0, 3'b000, 2, 7'b0010011), 8'h08, 2, 32'hffff_fffd, 1, 0);
        add_row(8'h08, enc_u(20'h12345, 3, 7'b0110111), 8'h0c, 3, 32'h1234_5000, 1, 0);
        add_row(8'h0c, enc_u(20'h00001, 4, 7'b0010111), 8'h10, 4, 32'h8000_100c, 1, 0);
        add_row(8'h10, enc_r(7'h20, 2, 1, 3'b000, 5), 8'h14, 5, 32'd8, 1, 0);        // sub
        add_row(8'h14, enc_r(7'h00, 1, 1, 3'b001, 6), 8'h18, 6, 32'h0000_00a0, 1, 0); // sll
        add_row(8'h18, enc_r(7'h00, 1, 2, 3'b010, 7), 8'h1c, 7, 32'd1, 1, 0);        // slt
        add_row(8'h1c, enc_r(7'h00, 1, 2, 3'b011, 8), 8'h20, 8, 32'd0, 1, 0);        // sltu
        add_row(8'h20, enc_r(7'h00, 2, 1, 3'b100, 9), 8'h24, 9, 32'hffff_fff8, 1, 0);
        add_row(8'h24, enc_r(7'h00, 1, 2, 3'b101, 10), 8'h28, 10, 32'h07ff_ffff, 1, 0);
        add_row(8'h28, enc_r(7'h20, 1, 2, 3'b101, 11), 8'h2c, 11, 32'hffff_ffff, 1, 0);
        add_row(8'h2c, enc_r(7'h00, 3, 1, 3'b110, 12), 8'h30, 12, 32'h1234_5005, 1, 0);
        add_row(8'h30, enc_r(7'h00, 1, 2, 3'b111, 13), 8'h34, 13, 32'd5, 1, 0);
        // x1 = 5, x2 = -3; each branch taken, then not taken
        add_row(8'h34, enc_b(13'd8, 1, 1, 3'b000), 8'h3c, 0, 32'd0, 0, 0);
        add_row(8'h3c, enc_b(13'd8, 2, 1, 3'b000), 8'h40, 0, 32'd0, 0, 0);
        add_row(8'h40, enc_b(13'd8, 2, 1, 3'b001), 8'h48, 0, 32'd0, 0, 0);
        add_row(8'h48, enc_b(13'd8, 1, 1, 3'b001), 8'h4c, 0, 32'd0, 0, 0);
        add_row(8'h4c, enc_b(13'd8, 1, 2, 3'b100), 8'h54, 0, 32'd0, 0, 0);
        add_row(8'h54, enc_b(13'd8, 2, 1, 3'b100), 8'h58, 0, 32'd0, 0, 0);
        add_row(8'h58, enc_b(13'd8, 2, 1, 3'b101), 8'h60, 0, 32'd0, 0, 0);
        add_row(8'h60, enc_b(13'd8, 1, 2, 3'b101), 8'h64, 0, 32'd0, 0, 0);
        add_row(8'h64, enc_b(13'd8, 2, 1, 3'b110), 8'h6c, 0, 32'd0, 0, 0);
        add_row(8'h6c, enc_b(13'd8, 1, 2, 3'b110), 8'h70, 0, 32'd0, 0, 0);
        add_row(8'h70, enc_b(13'd8, 1, 2, 3'b111), 8'h78, 0, 32'd0, 0, 0);
        add_row(8'h78, enc_b(13'd8, 2, 1, 3'b111), 8'h7c, 0, 32'd0, 0, 0);
        add_row(8'h7c, enc_j(21'd12, 14), 8'h88, 14, 32'h8000_0080, 1, 0);
        // target 0x80000091, bit 0 dropped, skips the word at 0x8c
        add_row(8'h88, enc_i(12'd17, 14, 3'b000, 15, 7'b1100111), 8'h90, 15, 32'h8000_008c, 1, 0);
        add_row(8'h90, enc_i(12'd7, 1, 3'b000, 0, 7'b0010011), 8'h94, 0, 32'd12, 1, 0);
        add_row(8'h94, enc_r(7'h00, 1, 0, 3'b000, 16), 8'h98, 16, 32'd5, 1, 0);  // x0 + x1
        add_row(8'h98, 32'h0000_2083, 8'h9c, 0, 32'd0, 0, 1);  // lw, dropped from the core
    endtask

    // instruction memory with random latency
    task automatic serve_fetches();
        int          cycles;
        int          delay;
        logic [31:0] addr;
        forever begin
            cycles = 0;
            do begin
                @(posedge clk);
                #1;
                cycles++;
            end while (!fetch_req.valid && cycles < 50);
            if (!fetch_req.valid)
                report_timeout("no fetch request");
            addr = fetch_req.pc;
            if (first_fetch) begin
                check_value("fetch_req.pc", addr, core_bus_pkg::RESET_PC);
                first_fetch = 1'b0;
            end
            delay = $unsigned($random(seed)) % 4;
            repeat (delay + 1) @(posedge clk);
            #1;
            fetch_rsp.valid = 1'b1;
            fetch_rsp.inst  = imem[(addr - core_bus_pkg::RESET_PC) >> 2];
            @(posedge clk);
            #1;
            fetch_rsp = '0;
        end
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!retire.valid && cycles < 50);
        if (!retire.valid)
            report_timeout("no instruction retired");
    endtask

    initial begin
        fetch_rsp = '0;
        reset     = 1'b1;
        build_program();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            serve_fetches();
        join_none
        for (int n = 0; n < trace.size(); n++) begin
            wait_retire();
            check_value("retire.pc", retire.pc, trace[n].pc);  // rows chain from last next_pc
            check_value("retire.next_pc", retire.next_pc, trace[n].next_pc);
            check_value("retire.rd", 32'(retire.rd), 32'(trace[n].rd));
            check_value("retire.wdata", retire.wdata, trace[n].wdata);
            check_value("retire.we", 32'(retire.we), 32'(trace[n].we));
            check_value("retire.illegal", 32'(retire.illegal), 32'(trace[n].illegal));
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: execute/exec_unit.sv
// ====================
// combinational execute and write-back; register writes gated by exec_stb
// ====================
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  rv_isa_pkg::decoded_t          decoded,
    input  logic [core_bus_pkg::XLEN-1:0] rdata1,
    input  logic [core_bus_pkg::XLEN-1:0] rdata2,
    input  logic                          exec_stb,
    output logic [core_bus_pkg::XLEN-1:0] next_pc,
    output core_bus_pkg::wb_t             wb,
    output core_bus_pkg::retire_t         retire
);

    logic [core_bus_pkg::XLEN-1:0] alu_a;
    logic [core_bus_pkg::XLEN-1:0] alu_b;
    logic [core_bus_pkg::XLEN-1:0] alu_result;
    logic [4:0]                    shamt;
    logic                          taken;
    logic                          is_jump;  // JAL or JALR
    logic                          we_raw;
    logic [core_bus_pkg::XLEN-1:0] wdata;

    // operand choice by class
    always_comb begin
        alu_a = rdata1;
        alu_b = decoded.imm;
        case (decoded.op_class)
            rv_isa_pkg::CLASS_R: alu_b = rdata2;
            rv_isa_pkg::CLASS_U:
                alu_a = (decoded.opcode == rv_isa_pkg::OPC_LUI) ? '0 : decoded.pc;
            rv_isa_pkg::CLASS_B, rv_isa_pkg::CLASS_J: alu_a = decoded.pc;
            default: ;
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (decoded.alu_op)
            rv_isa_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            rv_isa_pkg::ALU_SLL:  alu_result = alu_a << shamt;
            rv_isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_isa_pkg::ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            rv_isa_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            rv_isa_pkg::ALU_SRL:  alu_result = alu_a >> shamt;
            rv_isa_pkg::ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
            rv_isa_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            rv_isa_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            default:              alu_result = alu_a + alu_b;
        endcase
    end

    // branch condition always compares the register operands
    always_comb begin
        case (decoded.funct3)
            rv_isa_pkg::FUNCT3_BEQ:  taken = (rdata1 == rdata2);
            rv_isa_pkg::FUNCT3_BNE:  taken = (rdata1 != rdata2);
            rv_isa_pkg::FUNCT3_BLT:  taken = ($signed(rdata1) < $signed(rdata2));
            rv_isa_pkg::FUNCT3_BGE:  taken = ($signed(rdata1) >= $signed(rdata2));
            rv_isa_pkg::FUNCT3_BLTU: taken = (rdata1 < rdata2);
            rv_isa_pkg::FUNCT3_BGEU: taken = (rdata1 >= rdata2);
            default:                 taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = decoded.snpc;
        if (decoded.opcode == rv_isa_pkg::OPC_JALR)
            next_pc = {alu_result[31:1], 1'b0};
        else if (decoded.op_class == rv_isa_pkg::CLASS_J)
            next_pc = alu_result;
        else if (decoded.op_class == rv_isa_pkg::CLASS_B && taken)
            next_pc = alu_result;  // pc + branch offset
    end

    assign is_jump = (decoded.op_class == rv_isa_pkg::CLASS_J)
                  || (decoded.opcode == rv_isa_pkg::OPC_JALR);
    // branches and illegal opcodes write nothing
    assign we_raw  = (decoded.op_class == rv_isa_pkg::CLASS_R)
                  || (decoded.op_class == rv_isa_pkg::CLASS_I)
                  || (decoded.op_class == rv_isa_pkg::CLASS_U)
                  || (decoded.op_class == rv_isa_pkg::CLASS_J);
    assign wdata   = is_jump ? decoded.snpc : alu_result;

    assign wb.we    = we_raw && exec_stb;
    assign wb.rd    = decoded.rd;
    assign wb.wdata = wdata;

    assign retire.valid   = exec_stb;
    assign retire.pc      = decoded.pc;
    assign retire.next_pc = next_pc;
    assign retire.rd      = we_raw ? decoded.rd : 5'd0;  // rd bits are imm on branches
    assign retire.wdata   = we_raw ? wdata : '0;
    assign retire.we      = we_raw;
    assign retire.illegal = decoded.illegal;

endmodule

`default_nettype wire

// File: fetch/fetch_unit.sv
// ====================
// memory answers at least one cycle after the request strobe
// ====================
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                          clk,
    input  logic                          reset,
    output core_bus_pkg::fetch_req_t      fetch_req,
    input  core_bus_pkg::fetch_rsp_t      fetch_rsp,
    input  logic [core_bus_pkg::XLEN-1:0] next_pc,
    output logic [core_bus_pkg::XLEN-1:0] pc,
    output logic [core_bus_pkg::XLEN-1:0] inst,
    output logic                          exec_stb
);

    // REQUEST is only visited once, right after reset
    typedef enum logic [1:0] {
        REQUEST,
        WAIT,
        EXECUTE
    } state_t;

    state_t state, state_next;
    logic   req_stb;
    logic   rsp_accept;

    // a response in the request cycle itself is not ours
    assign rsp_accept = fetch_rsp.valid && (state == WAIT) && !req_stb;
    assign exec_stb   = (state == EXECUTE);

    always_comb begin
        state_next = state;
        case (state)
            REQUEST: state_next = WAIT;
            WAIT:    if (rsp_accept) state_next = EXECUTE;
            EXECUTE: state_next = WAIT;  // next request goes out with the new pc
            default: state_next = REQUEST;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= REQUEST;
            req_stb <= 1'b0;
            pc      <= core_bus_pkg::RESET_PC;
        end else begin
            state   <= state_next;
            req_stb <= (state == REQUEST) || (state == EXECUTE);
            if (exec_stb)
                pc <= next_pc;  // lands together with the register write
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (rsp_accept)
            inst <= fetch_rsp.inst;
    end

    assign fetch_req.valid = req_stb;
    assign fetch_req.pc    = pc;

endmodule

`default_nettype wire

// File: flist.f
common/rv_isa_pkg.sv
common/core_bus_pkg.sv
source/reg_file.sv
fetch/fetch_unit.sv
decode/inst_decoder.sv
execute/exec_unit.sv
source/rv_core.sv
dv/rv_core_tb.sv

// File: source/reg_file.sv
// ====================
// x0 reads zero and ignores writes; reads are combinational
// ====================
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [4:0]                    rs1,
    input  logic [4:0]                    rs2,
    output logic [core_bus_pkg::XLEN-1:0] rdata1,
    output logic [core_bus_pkg::XLEN-1:0] rdata2,
    input  core_bus_pkg::wb_t             wb
);

    logic [core_bus_pkg::XLEN-1:0] regs [core_bus_pkg::NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < core_bus_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb.we && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    // write-first is not needed, one instruction at a time
    always_comb begin
        rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
        rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
// ====================
// one instruction in flight; instruction memory sits outside the core
// ====================
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                     clk,
    input  logic                     reset,
    output core_bus_pkg::fetch_req_t fetch_req,
    input  core_bus_pkg::fetch_rsp_t fetch_rsp,
    output core_bus_pkg::retire_t    retire
);

    logic [core_bus_pkg::XLEN-1:0] pc;
    logic [core_bus_pkg::XLEN-1:0] inst;
    logic [core_bus_pkg::XLEN-1:0] next_pc;
    logic                          exec_stb;
    rv_isa_pkg::decoded_t          decoded;
    logic [core_bus_pkg::XLEN-1:0] rdata1;
    logic [core_bus_pkg::XLEN-1:0] rdata2;
    core_bus_pkg::wb_t             wb;

    fetch_unit u_fetch (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .next_pc   (next_pc),
        .pc        (pc),
        .inst      (inst),
        .exec_stb  (exec_stb)
    );

    inst_decoder u_decoder (
        .inst    (inst),
        .pc      (pc),
        .decoded (decoded)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .rs1    (decoded.rs1),
        .rs2    (decoded.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    exec_unit u_exec (
        .decoded  (decoded),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .exec_stb (exec_stb),
        .next_pc  (next_pc),
        .wb       (wb),
        .retire   (retire)
    );

endmodule

`default_nettype wire
